// ==== hw/controlPkg.sv ====
package controlPkg;

    localparam int OpcodeWidth = 6;
    localparam int FunctWidth = 6;
    localparam int AluOpWidth = 6;
    localparam int SelWidth = 2;

    typedef logic [OpcodeWidth-1:0] opcodeT;
    typedef logic [FunctWidth-1:0] functT;
    typedef logic [AluOpWidth-1:0] aluOpT;
    typedef logic [SelWidth-1:0] aluSrcBT;
    typedef logic [SelWidth-1:0] regDstT;

    // Opcode field encodings
    localparam opcodeT OpR = 6'b000000;
    localparam opcodeT OpAddi = 6'b001000;
    localparam opcodeT OpBeq = 6'b000100;
    localparam opcodeT OpBne = 6'b000101;
    localparam opcodeT OpBle = 6'b000110;
    localparam opcodeT OpBgt = 6'b000111;
    localparam opcodeT OpReset = 6'b111111;

    // Same codes as the R-type funct field
    localparam aluOpT AluAdd = 6'b100000;
    localparam aluOpT AluSub = 6'b100010;

    localparam aluSrcBT SrcBReg = 2'b00;
    localparam aluSrcBT SrcBFour = 2'b01;
    localparam aluSrcBT SrcBImm = 2'b10;

    localparam regDstT DstRt = 2'b00;
    localparam regDstT DstRd = 2'b01;

    typedef enum logic [1:0] {
        classAlu,
        classBranch,
        classHalt,
        classNone
    } instrClassT;

    // Order follows the low opcode bits of beq, bne, ble, bgt
    typedef enum logic [1:0] {
        condEq,
        condNe,
        condLe,
        condGt
    } branchCondT;

    typedef enum logic [3:0] {
        fetchReq,
        fetchLatch,
        fetchRelease,
        decode,
        execOperands,
        execAluOut,
        execWrite,
        execBranch,
        halt
    } stepT;

endpackage

// ==== hw/stepBus.sv ====
`timescale 1ns/1ps

interface stepBus;
    import controlPkg::*;

    stepT step;
    // Single cycle in fetchLatch
    logic latchPulse;
    // Low only while parked in halt
    logic stepValid;
    // Final execute step of the instruction
    logic lastStep;

    modport sequencer (
        output step,
        output latchPulse,
        output stepValid,
        output lastStep
    );

    modport driver (
        input step,
        input latchPulse,
        input stepValid,
        input lastStep
    );

endinterface

// ==== hw/decodeBus.sv ====
`timescale 1ns/1ps

interface decodeBus;
    import controlPkg::*;

    instrClassT instrClass;
    aluOpT aluOp;
    aluSrcBT aluSrcB;
    regDstT regDst;
    branchCondT branchCond;

    modport decoder (
        output instrClass,
        output aluOp,
        output aluSrcB,
        output regDst,
        output branchCond
    );

    // Shared by sequencer and driver
    modport consumer (
        input instrClass,
        input aluOp,
        input aluSrcB,
        input regDst,
        input branchCond
    );

endinterface

// ==== hw/instrSequencer.sv ====
`timescale 1ns/1ps

module instrSequencer (
    input  logic clock,
    input  logic reset,
    input  logic memAck,
    output logic memReq,
    stepBus.sequencer stepPort,
    decodeBus.consumer decodePort
);
    import controlPkg::*;

    stepT state;
    stepT nextState;
    logic lastStep;

    assign lastStep = (state == execWrite) || (state == execBranch);

    assign stepPort.step = state;
    assign stepPort.latchPulse = (state == fetchLatch);
    assign stepPort.stepValid = (state != halt);
    assign stepPort.lastStep = lastStep;

    always_comb begin
        nextState = state;
        case (state)
            // Wait for the instruction to be presented
            fetchReq: begin
                if (memAck) begin
                    nextState = fetchLatch;
                end
            end
            fetchLatch: begin
                nextState = fetchRelease;
            end
            // Memory drops ack to close the four-phase cycle
            fetchRelease: begin
                if (!memAck) begin
                    nextState = decode;
                end
            end
            decode: begin
                case (decodePort.instrClass)
                    classAlu: nextState = execOperands;
                    classBranch: nextState = execBranch;
                    classHalt: nextState = halt;
                    default: nextState = fetchReq;
                endcase
            end
            execOperands: begin
                nextState = execAluOut;
            end
            execAluOut: begin
                nextState = execWrite;
            end
            // Parked until external reset
            halt: begin
                nextState = halt;
            end
            default: begin
                nextState = state;
            end
        endcase

        if (lastStep) begin
            nextState = fetchReq;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= fetchReq;
            memReq <= 1'b0;
        end else begin
            state <= nextState;
            // Request held until the latch step, then released
            if (state == fetchReq) begin
                memReq <= 1'b1;
            end else if (state == fetchLatch) begin
                memReq <= 1'b0;
            end
        end
    end

endmodule

// ==== hw/opcodeDecoder.sv ====
`timescale 1ns/1ps

module opcodeDecoder (
    input controlPkg::opcodeT opcode,
    input controlPkg::functT funct,
    decodeBus.decoder decodePort
);
    import controlPkg::*;

    always_comb begin
        // Unknown opcodes fall back to no effect
        decodePort.instrClass = classNone;
        decodePort.aluOp = AluAdd;
        decodePort.aluSrcB = SrcBReg;
        decodePort.regDst = DstRt;
        decodePort.branchCond = condEq;

        case (opcode)
            OpR: begin
                decodePort.instrClass = classAlu;
                decodePort.aluOp = funct;
                decodePort.regDst = DstRd;
            end
            // Sign-extended immediate into rt
            OpAddi: begin
                decodePort.instrClass = classAlu;
                decodePort.aluOp = AluAdd;
                decodePort.aluSrcB = SrcBImm;
                decodePort.regDst = DstRt;
            end
            OpBeq, OpBne, OpBle, OpBgt: begin
                decodePort.instrClass = classBranch;
                decodePort.aluOp = AluSub;
                decodePort.aluSrcB = SrcBReg;
                // Low opcode bits select the condition
                decodePort.branchCond = branchCondT'(opcode[1:0]);
            end
            OpReset: begin
                decodePort.instrClass = classHalt;
            end
            default: begin
                decodePort.instrClass = classNone;
            end
        endcase
    end

endmodule

// ==== hw/controlDriver.sv ====
`timescale 1ns/1ps

module controlDriver (
    input  logic clock,
    input  logic reset,
    input  logic zero,
    input  logic negative,
    stepBus.driver stepPort,
    decodeBus.consumer decodePort,
    output logic pcWrite,
    output logic irWrite,
    output logic abWrite,
    output logic aluOutWrite,
    output logic regWrite,
    output logic pcWriteCond,
    output logic aluSrcA,
    output controlPkg::aluSrcBT aluSrcB,
    output controlPkg::regDstT regDst,
    output controlPkg::aluOpT aluOp,
    output logic eq,
    output logic gt,
    output logic lt,
    output logic resetOut
);
    import controlPkg::*;

    logic branchStep;
    branchCondT condReg;
    logic taken;

    // Flags come from the compare issued in the branch cycle itself
    always_comb begin
        case (condReg)
            condEq: taken = zero;
            condNe: taken = !zero;
            condLe: taken = zero || negative;
            default: taken = !zero && !negative;
        endcase
    end

    assign pcWriteCond = branchStep && taken;

    always_ff @(posedge clock) begin
        if (reset) begin
            pcWrite <= 1'b0;
            irWrite <= 1'b0;
            abWrite <= 1'b0;
            aluOutWrite <= 1'b0;
            regWrite <= 1'b0;
            aluSrcA <= 1'b0;
            aluSrcB <= SrcBReg;
            regDst <= DstRt;
            aluOp <= '0;
            eq <= 1'b0;
            gt <= 1'b0;
            lt <= 1'b0;
            resetOut <= 1'b1;
            branchStep <= 1'b0;
            condReg <= condEq;
        end else begin
            pcWrite <= stepPort.latchPulse;
            irWrite <= stepPort.latchPulse;
            abWrite <= (stepPort.step == decode);
            aluOutWrite <= (stepPort.step == execAluOut);
            resetOut <= !stepPort.stepValid;
            regWrite <= 1'b0;
            aluSrcA <= 1'b0;
            aluSrcB <= SrcBReg;
            regDst <= DstRt;
            aluOp <= '0;
            eq <= 1'b0;
            gt <= 1'b0;
            lt <= 1'b0;
            branchStep <= 1'b0;

            case (stepPort.step)
                // PC + 4 set up during the whole fetch
                fetchReq, fetchLatch, fetchRelease: begin
                    aluOp <= AluAdd;
                    aluSrcB <= SrcBFour;
                end
                execOperands, execAluOut, execWrite, execBranch: begin
                    aluSrcA <= 1'b1;
                    aluOp <= decodePort.aluOp;
                    aluSrcB <= decodePort.aluSrcB;
                end
                default: begin
                    aluOp <= '0;
                end
            endcase

            if (stepPort.lastStep) begin
                case (decodePort.instrClass)
                    classAlu: begin
                        regWrite <= 1'b1;
                        regDst <= decodePort.regDst;
                    end
                    classBranch: begin
                        branchStep <= 1'b1;
                        condReg <= decodePort.branchCond;
                        // bne drives none of the compare selects
                        eq <= (decodePort.branchCond == condEq);
                        gt <= (decodePort.branchCond == condGt);
                        lt <= (decodePort.branchCond == condLe);
                    end
                    default: begin
                        branchStep <= 1'b0;
                    end
                endcase
            end
        end
    end

endmodule

// ==== hw/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit (
    input  logic clock,
    input  logic reset,
    input  logic memAck,
    input  logic zero,
    input  logic negative,
    input  controlPkg::opcodeT opcode,
    input  controlPkg::functT funct,
    output logic memReq,
    output logic pcWrite,
    output logic irWrite,
    output logic abWrite,
    output logic aluOutWrite,
    output logic regWrite,
    output logic pcWriteCond,
    output logic aluSrcA,
    output controlPkg::aluSrcBT aluSrcB,
    output controlPkg::regDstT regDst,
    output controlPkg::aluOpT aluOp,
    output logic eq,
    output logic gt,
    output logic lt,
    output logic resetOut
);

    stepBus stepIf ();
    decodeBus decodeIf ();

    instrSequencer sequencer (
        .clock(clock),
        .reset(reset),
        .memAck(memAck),
        .memReq(memReq),
        .stepPort(stepIf.sequencer),
        .decodePort(decodeIf.consumer)
    );

    opcodeDecoder decoder (
        .opcode(opcode),
        .funct(funct),
        .decodePort(decodeIf.decoder)
    );

    controlDriver driver (
        .clock(clock),
        .reset(reset),
        .zero(zero),
        .negative(negative),
        .stepPort(stepIf.driver),
        .decodePort(decodeIf.consumer),
        .pcWrite(pcWrite),
        .irWrite(irWrite),
        .abWrite(abWrite),
        .aluOutWrite(aluOutWrite),
        .regWrite(regWrite),
        .pcWriteCond(pcWriteCond),
        .aluSrcA(aluSrcA),
        .aluSrcB(aluSrcB),
        .regDst(regDst),
        .aluOp(aluOp),
        .eq(eq),
        .gt(gt),
        .lt(lt),
        .resetOut(resetOut)
    );

endmodule

// ==== testbench/controlUnit_asserts.sv ====
`timescale 1ns/1ps

module controlUnitAsserts (
    input logic clock,
    input logic reset,
    input logic memReq,
    input logic memAck,
    input logic pcWrite,
    input logic irWrite,
    input logic eq,
    input logic gt,
    input logic lt,
    input logic resetOut
);

    // New request only once the previous ack is gone
    reqAfterAckLow: assert property (@(posedge clock) disable iff (reset)
        $rose(memReq) |-> !memAck)
        else $error("memReq rose while memAck was high");

    pcWithIr: assert property (@(posedge clock) disable iff (reset)
        pcWrite |-> irWrite)
        else $error("pcWrite high without irWrite");

    compareSelect: assert property (@(posedge clock) disable iff (reset)
        $onehot0({eq, gt, lt}))
        else $error("more than one of eq, gt, lt high");

    // resetOut is registered, so one edge of reset comes first
    resetHeld: assert property (@(posedge clock)
        reset && $past(reset) |-> resetOut)
        else $error("resetOut low while reset is high");

endmodule

bind controlUnit controlUnitAsserts asserts (.*);

// ==== testbench/controlUnitTb.sv ====
`timescale 1ns/1ps

module controlUnitTb;
    import controlPkg::*;

    // About 25 instructions of at most 20 cycles, plus reset and halt, with margin
    localparam int CycleLimit = 2000;
    localparam int ResetCycles = 8;
    localparam int HaltCycles = 20;
    localparam int FetchLimit = 30;

    logic clock = 1'b0;
    logic reset = 1'b1;
    logic memAck = 1'b0;
    logic zero = 1'b0;
    logic negative = 1'b0;
    opcodeT opcode = '0;
    functT funct = '0;
    logic memReq;
    logic pcWrite;
    logic irWrite;
    logic abWrite;
    logic aluOutWrite;
    logic regWrite;
    logic pcWriteCond;
    logic aluSrcA;
    aluSrcBT aluSrcB;
    regDstT regDst;
    aluOpT aluOp;
    logic eq;
    logic gt;
    logic lt;
    logic resetOut;
    logic [20:0] controls;

    opcodeT nextOpcode = '0;
    functT nextFunct = '0;
    int ackDelay = 0;
    int errorCount = 0;
    int testCount = 0;
    int cycleCount = 0;

    assign controls = {memReq, pcWrite, irWrite, abWrite, aluOutWrite, regWrite, pcWriteCond,
        aluSrcA, aluSrcB, regDst, aluOp, eq, gt, lt};

    controlUnit DUT (.*);

    initial begin
        forever #2 clock = ~clock;
    end

    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
    end

    initial begin
        wait (cycleCount >= CycleLimit);
        $display("Run stopped after %0d cycles without finishing", CycleLimit);
        $display("Testbench failed");
        $finish;
    end

    // Instruction memory side of the four-phase fetch
    initial begin
        int delay;
        delay = -1;
        forever begin
            @(posedge clock);
            if (reset) begin
                memAck <= 1'b0;
                delay = -1;
            end else if (memAck) begin
                if (!memReq) begin
                    memAck <= 1'b0;
                end
            end else if (memReq && delay < 0) begin
                delay = ackDelay;
            end
            if (!reset && !memAck && delay == 0) begin
                memAck <= 1'b1;
                opcode <= nextOpcode;
                funct <= nextFunct;
                delay = -1;
            end else if (delay > 0) begin
                delay = delay - 1;
            end
        end
    end

    task automatic reportMismatch(input string name, input logic [31:0] actual,
        input logic [31:0] expected);
        errorCount++;
        $display("FAIL %s: got 0x%0h, expected 0x%0h at %0t ns", name, actual, expected, $time);
    endtask

    task automatic reportProblem(input string what);
        errorCount++;
        $display("Error at %0t ns: %s", $time, what);
    endtask

    // Next instruction word and the memory's ack delay for its fetch
    task automatic presentInstr(input opcodeT op, input functT fn);
        nextOpcode = op;
        nextFunct = fn;
        ackDelay = $urandom_range(5, 0);
    endtask

    // Drop reset, then expect the first fetch request
    task automatic releaseReset;
        @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        if (resetOut !== 1'b1) reportMismatch("resetOut", 32'(resetOut), 32'd1);
        if (controls !== '0) reportMismatch("control outputs", 32'(controls), 32'd0);
        @(negedge clock);
        if (resetOut !== 1'b0) reportMismatch("resetOut", 32'(resetOut), 32'd0);
        if (memReq !== 1'b1) reportMismatch("memReq", 32'(memReq), 32'd1);
    endtask

    task automatic testReset;
        testCount++;
        repeat (ResetCycles - 1) begin
            @(negedge clock);
            if (resetOut !== 1'b1) reportMismatch("resetOut", 32'(resetOut), 32'd1);
            if (controls !== '0) reportMismatch("control outputs", 32'(controls), 32'd0);
        end
        releaseReset();
    endtask

    // Fetch and decode, returning in the cycle that shows abWrite
    task automatic fetchInstr;
        int n;
        int ackAt;
        int pulses;
        ackAt = -1;
        pulses = 0;
        for (n = 0; n < FetchLimit && abWrite !== 1'b1; n++) begin
            @(negedge clock);
            if (memAck && ackAt < 0) begin
                ackAt = n;
            end
            if (pulses > 0 && memAck && memReq) reportProblem("memReq rose before memAck fell");
            if (pcWrite || irWrite) begin
                pulses++;
                if (pcWrite !== 1'b1) reportMismatch("pcWrite", 32'(pcWrite), 32'd1);
                if (irWrite !== 1'b1) reportMismatch("irWrite", 32'(irWrite), 32'd1);
                if (memReq !== 1'b0) reportMismatch("memReq", 32'(memReq), 32'd0);
                // Ack sampled on the next edge, pulse registered one edge later
                if (n != ackAt + 2) reportProblem("pcWrite did not follow memAck by one cycle");
            end
        end
        if (abWrite !== 1'b1) reportProblem("no abWrite pulse after the fetch");
        if (pulses != 1) reportMismatch("pcWrite pulses", 32'(pulses), 32'd1);
    endtask

    task automatic runAlu(input opcodeT op, input functT fn, input aluOpT expOp,
        input aluSrcBT expSrcB, input regDstT expDst);
        testCount++;
        presentInstr(op, fn);
        fetchInstr();
        @(negedge clock);
        if (abWrite !== 1'b0) reportProblem("abWrite held longer than one cycle");
        if (aluSrcA !== 1'b1) reportMismatch("aluSrcA", 32'(aluSrcA), 32'd1);
        if (aluOp !== expOp) reportMismatch("aluOp", 32'(aluOp), 32'(expOp));
        if (aluSrcB !== expSrcB) reportMismatch("aluSrcB", 32'(aluSrcB), 32'(expSrcB));
        @(negedge clock);
        if (aluOutWrite !== 1'b1) reportMismatch("aluOutWrite", 32'(aluOutWrite), 32'd1);
        if (regWrite !== 1'b0) reportMismatch("regWrite", 32'(regWrite), 32'd0);
        @(negedge clock);
        if (aluOutWrite !== 1'b0) reportProblem("aluOutWrite held longer than one cycle");
        if (regWrite !== 1'b1) reportMismatch("regWrite", 32'(regWrite), 32'd1);
        if (regDst !== expDst) reportMismatch("regDst", 32'(regDst), 32'(expDst));
        @(negedge clock);
        if (regWrite !== 1'b0) reportProblem("regWrite held longer than one cycle");
    endtask

    task automatic runBranch(input opcodeT op, input logic z, input logic n);
        logic taken;
        logic [2:0] selects;
        testCount++;
        presentInstr(op, '0);
        // Expected compare selects as {eq, gt, lt}
        case (op)
            OpBeq: begin
                taken = z;
                selects = 3'b100;
            end
            OpBne: begin
                taken = !z;
                selects = 3'b000;
            end
            OpBle: begin
                taken = z || n;
                selects = 3'b001;
            end
            default: begin
                taken = !z && !n;
                selects = 3'b010;
            end
        endcase
        @(posedge clock);
        zero <= z;
        negative <= n;
        fetchInstr();
        @(negedge clock);
        if (aluOp !== AluSub) reportMismatch("aluOp", 32'(aluOp), 32'(AluSub));
        if ({eq, gt, lt} !== selects) reportMismatch("eq/gt/lt", 32'({eq, gt, lt}), 32'(selects));
        if (pcWriteCond !== taken) reportMismatch("pcWriteCond", 32'(pcWriteCond), 32'(taken));
    endtask

    task automatic runUnknown;
        testCount++;
        // lw is not handled by this unit
        presentInstr(6'b100011, '0);
        fetchInstr();
        @(negedge clock);
        if ({aluSrcA, aluOutWrite, regWrite, pcWriteCond} !== 4'b0) begin
            reportProblem("unknown opcode drove an execute control");
        end
        if (memReq !== 1'b1) reportMismatch("memReq", 32'(memReq), 32'd1);
    endtask

    task automatic runHalt;
        int i;
        testCount++;
        presentInstr(OpReset, '0);
        fetchInstr();
        for (i = 0; i < HaltCycles; i++) begin
            @(negedge clock);
            if (resetOut !== 1'b1) reportMismatch("resetOut", 32'(resetOut), 32'd1);
            if (controls !== '0) reportMismatch("control outputs", 32'(controls), 32'd0);
        end
        @(posedge clock);
        reset <= 1'b1;
        @(posedge clock);
        releaseReset();
    endtask

    initial begin
        opcodeT branchOps[4];
        functT fn;
        int i;
        branchOps = '{OpBeq, OpBne, OpBle, OpBgt};
        void'($urandom(12692));
        testReset();
        repeat (3) begin
            fn = 6'($urandom_range(63, 0));
            runAlu(OpR, fn, fn, SrcBReg, DstRd);
        end
        runAlu(OpAddi, 6'($urandom_range(63, 0)), AluAdd, SrcBImm, DstRt);
        for (i = 0; i < 16; i++) begin
            runBranch(branchOps[i / 4], i[1], i[0]);
        end
        runUnknown();
        runAlu(OpAddi, '0, AluAdd, SrcBImm, DstRt);
        runHalt();
        runAlu(OpAddi, '0, AluAdd, SrcBImm, DstRt);

        $display("Tests run: %0d, errors: %0d", testCount, errorCount);
        if (errorCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
hw/controlPkg.sv
hw/stepBus.sv
hw/decodeBus.sv
hw/instrSequencer.sv
hw/opcodeDecoder.sv
hw/controlDriver.sv
hw/controlUnit.sv
testbench/controlUnit_asserts.sv
testbench/controlUnitTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the control unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module controlUnitTb -f tb.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/VcontrolUnitTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1
